//--- src/mips_pkg.sv
package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011,
        OP_BEQ   = 6'b000100,
        OP_ADDI  = 6'b001000,
        OP_J     = 6'b000010
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_SLT = 6'b101010
    } funct_t;

    // Operation class handed from main decoder to ALU decoder
    typedef enum logic [1:0] {
        ALUC_ADD   = 2'b00,
        ALUC_SUB   = 2'b01,
        ALUC_FUNCT = 2'b10
    } alu_class_t;

    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } alu_op_t;

    typedef struct packed {
        opcode_t    op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } instr_t;

    typedef struct packed {
        logic    regwrite;
        logic    regdst;
        logic    alusrc;
        logic    branch;
        logic    memwrite;
        logic    memtoreg;
        logic    jump;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] addr;              // Byte address with the word in [31:2]
        logic [31:0] wdata;
        logic        we;
    } dmem_req_t;

endpackage

//--- src/maindec.sv
`timescale 1ns/1ns

module maindec (
    input  mips_pkg::opcode_t    op,
    output logic                 regwrite,
    output logic                 regdst,
    output logic                 alusrc,
    output logic                 branch,
    output logic                 memwrite,
    output logic                 memtoreg,
    output logic                 jump,
    output mips_pkg::alu_class_t alu_class,
    output logic                 op_valid
);
    import mips_pkg::*;

    logic [6:0] controls;

    assign {regwrite, regdst, alusrc, branch, memwrite, memtoreg, jump} = controls;

    always_comb begin
        alu_class = ALUC_ADD;
        op_valid  = 1'b1;
        case (op)
            OP_RTYPE: begin
                controls  = 7'b1100000;
                alu_class = ALUC_FUNCT;
            end
            OP_LW:   controls = 7'b1010010;
            OP_SW:   controls = 7'b0010100;
            OP_BEQ: begin
                controls  = 7'b0001000;
                alu_class = ALUC_SUB;   // Compare by subtraction
            end
            OP_ADDI: controls = 7'b1010000;
            OP_J:    controls = 7'b0000001;
            default: begin
                controls = 7'b0000000;  // Unknown opcode is a no-op
                op_valid = 1'b0;
            end
        endcase
    end

endmodule

//--- src/aludec.sv
`timescale 1ns/1ns

module aludec (
    input  mips_pkg::funct_t     funct,
    input  mips_pkg::alu_class_t alu_class,
    output mips_pkg::alu_op_t    alu_op,
    output logic                 funct_valid
);
    import mips_pkg::*;

    alu_op_t rtype_op;
    logic    rtype_valid;

    always_comb begin
        rtype_valid = 1'b1;
        case (funct)
            FN_ADD:  rtype_op = ALU_ADD;
            FN_SUB:  rtype_op = ALU_SUB;
            FN_AND:  rtype_op = ALU_AND;
            FN_OR:   rtype_op = ALU_OR;
            FN_SLT:  rtype_op = ALU_SLT;
            default: begin
                rtype_op    = ALU_ADD;
                rtype_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        funct_valid = 1'b1;
        case (alu_class)
            ALUC_ADD: alu_op = ALU_ADD;     // Loads, stores, addi
            ALUC_SUB: alu_op = ALU_SUB;     // beq
            default: begin
                alu_op      = rtype_op;
                funct_valid = rtype_valid;
            end
        endcase
    end

endmodule

//--- src/controller.sv
`timescale 1ns/1ns

module controller (
    input  logic              clk,
    input  mips_pkg::opcode_t op,
    input  mips_pkg::funct_t  funct,
    input  logic              zero,
    output mips_pkg::ctrl_t   ctrl,
    output logic              pcsrc
);
    import mips_pkg::*;

    alu_class_t alu_class;
    logic       op_valid;
    logic       funct_valid;
    logic       md_regwrite;
    logic       md_memwrite;
    logic       instr_valid;

    maindec md (
        .op        (op),
        .regwrite  (md_regwrite),
        .regdst    (ctrl.regdst),
        .alusrc    (ctrl.alusrc),
        .branch    (ctrl.branch),
        .memwrite  (md_memwrite),
        .memtoreg  (ctrl.memtoreg),
        .jump      (ctrl.jump),
        .alu_class (alu_class),
        .op_valid  (op_valid)
    );

    aludec ad (
        .funct       (funct),
        .alu_class   (alu_class),
        .alu_op      (ctrl.alu_op),
        .funct_valid (funct_valid)
    );

    // Unknown op or funct must not touch state
    assign instr_valid   = op_valid & funct_valid;
    assign ctrl.regwrite = md_regwrite & instr_valid;
    assign ctrl.memwrite = md_memwrite & instr_valid;

    assign pcsrc = ctrl.branch & zero;

endmodule

//--- src/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  mips_pkg::alu_op_t op,
    output logic [31:0]       y,
    output logic              zero
);
    import mips_pkg::*;

    logic [31:0] sum;
    logic [31:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_ADD: y = sum;
            ALU_SUB: y = diff;
            ALU_SLT: y = {31'b0, $signed(a) < $signed(b)};  // Signed compare
            default: y = '0;
        endcase
    end

    // Drives beq through pcsrc
    assign zero = (y == 32'b0);

endmodule

//--- src/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] rf [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            rf[wa] <= wd;       // $0 stays zero
        end
    end

    // Combinational reads
    assign rd1 = (ra1 == 5'd0) ? 32'b0 : rf[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'b0 : rf[ra2];

endmodule

//--- src/datapath.sv
`timescale 1ns/1ns

module datapath #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::ctrl_t     ctrl,
    input  logic                pcsrc,
    input  mips_pkg::instr_t    instr,
    input  logic [31:0]         rdata,
    output logic [31:0]         pc,
    output logic                zero,
    output mips_pkg::dmem_req_t dmem_req
);

    logic [31:0] pc_next;
    logic [31:0] pc_plus4;
    logic [31:0] pc_branch;
    logic [31:0] pc_jump;
    logic [31:0] signimm;
    logic [4:0]  write_reg;
    logic [31:0] src_a;
    logic [31:0] write_data;
    logic [31:0] src_b;
    logic [31:0] alu_y;
    logic [31:0] result;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4  = pc + 32'd4;
    assign signimm   = {{16{instr[15]}}, instr[15:0]};
    assign pc_branch = pc_plus4 + {signimm[29:0], 2'b00};
    assign pc_jump   = {pc_plus4[31:28], instr[25:0], 2'b00};

    // Branch has priority over jump over sequential
    always_comb begin
        if (pcsrc) begin
            pc_next = pc_branch;
        end else if (ctrl.jump) begin
            pc_next = pc_jump;
        end else begin
            pc_next = pc_plus4;
        end
    end

    assign write_reg = ctrl.regdst ? instr.rd : instr.rt;

    regfile rf (
        .clk (clk),
        .rst (rst),
        .we  (ctrl.regwrite & ~rst),
        .ra1 (instr.rs),
        .ra2 (instr.rt),
        .wa  (write_reg),
        .wd  (result),
        .rd1 (src_a),
        .rd2 (write_data)
    );

    assign src_b = ctrl.alusrc ? signimm : write_data;

    alu u_alu (
        .a    (src_a),
        .b    (src_b),
        .op   (ctrl.alu_op),
        .y    (alu_y),
        .zero (zero)
    );

    assign result = ctrl.memtoreg ? rdata : alu_y;   // Load or ALU write-back

    assign dmem_req.addr  = alu_y;
    assign dmem_req.wdata = write_data;
    assign dmem_req.we    = ctrl.memwrite & ~rst;    // No store while in reset

endmodule

//--- src/mips.sv
`timescale 1ns/1ns

module mips #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic                clk,
    input  logic                rst,
    output logic [31:0]         pc,
    input  mips_pkg::instr_t    instr,
    output mips_pkg::dmem_req_t dmem_req,
    input  logic [31:0]         rdata
);
    import mips_pkg::*;

    ctrl_t ctrl;
    logic  pcsrc;
    logic  zero;

    controller u_controller (
        .clk   (clk),
        .op    (instr.op),
        .funct (instr.funct),
        .zero  (zero),
        .ctrl  (ctrl),
        .pcsrc (pcsrc)
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .pcsrc    (pcsrc),
        .instr    (instr),
        .rdata    (rdata),
        .pc       (pc),
        .zero     (zero),
        .dmem_req (dmem_req)
    );

endmodule

//--- testbench/mips_properties.sv
`timescale 1ns/1ns

module mips_properties (
    input logic              clk,
    input mips_pkg::opcode_t op,
    input mips_pkg::funct_t  funct,
    input mips_pkg::ctrl_t   ctrl
);
    import mips_pkg::*;

    int   fail_count = 0;
    logic known;

    assign known = (op inside {OP_LW, OP_SW, OP_BEQ, OP_ADDI, OP_J}) ||
                   (op == OP_RTYPE && (funct inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT}));

    one_write: assert property (@(posedge clk) disable iff ($isunknown({op, funct}))
        !(ctrl.memwrite && ctrl.regwrite))
    else begin
        fail_count++;
        $error("memwrite and regwrite set together");
    end

    jump_no_write: assert property (@(posedge clk) disable iff ($isunknown({op, funct}))
        ctrl.jump |-> !ctrl.regwrite)
    else begin
        fail_count++;
        $error("jump with a register write");
    end

    unknown_no_write: assert property (@(posedge clk) disable iff ($isunknown({op, funct}))
        !known |-> !ctrl.regwrite && !ctrl.memwrite)
    else begin
        fail_count++;
        $error("unknown instruction writes state");
    end

endmodule

bind controller mips_properties props (
    .clk   (clk),
    .op    (op),
    .funct (funct),
    .ctrl  (ctrl)
);

//--- testbench/mips_tb.sv
`timescale 1ns/1ns

module mips_tb;
    import mips_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam int          BASE     = RESET_PC / 4;

    logic        clk;
    logic        rst = 1'b1;
    logic [31:0] pc;
    instr_t      instr;
    dmem_req_t   dmem_req;
    logic [31:0] rdata;

    logic [31:0] imem [1024];
    logic [31:0] dmem [64];
    logic [31:0] m_rf [32];             // Reference model state
    logic [31:0] m_mem [64];
    logic [31:0] m_pc;
    logic [31:0] prog [$];
    integer      seed = 32'h6393;
    bit          running = 1'b0;
    string       test_name;
    funct_t      fns [5] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};

    mips #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .instr    (instr),
        .dmem_req (dmem_req),
        .rdata    (rdata)
    );

    // Word-indexed memories answer combinationally
    assign instr = instr_t'(imem[pc[11:2]]);
    assign rdata = dmem[dmem_req.addr[7:2]];

    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] r_type(input funct_t fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(input opcode_t op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input logic [25:0] target);
        return {OP_J, target};
    endfunction

    // Steps the model state by one instruction and returns the expected request
    function automatic dmem_req_t ref_step(input logic [31:0] iw);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] nxt;
        logic [31:0] wval;
        logic [4:0]  wreg;
        dmem_req_t   req;
        a    = m_rf[iw[25:21]];
        b    = m_rf[iw[20:16]];
        simm = {{16{iw[15]}}, iw[15:0]};
        addr = a + simm;
        nxt  = m_pc + 32'd4;
        wreg = 5'd0;                    // $0 also means no write
        wval = 32'h0;
        req  = '0;
        case (iw[31:26])
            OP_RTYPE: begin
                wreg = iw[15:11];
                case (iw[5:0])
                    FN_ADD:  wval = a + b;
                    FN_SUB:  wval = a - b;
                    FN_AND:  wval = a & b;
                    FN_OR:   wval = a | b;
                    FN_SLT:  wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wreg = 5'd0;
                endcase
            end
            OP_LW: begin
                wreg = iw[20:16];
                wval = m_mem[addr[7:2]];
            end
            OP_SW: begin
                req.addr         = addr;
                req.wdata        = b;
                req.we           = 1'b1;
                m_mem[addr[7:2]] = b;
            end
            OP_BEQ: begin
                if (a == b) begin
                    nxt = nxt + {simm[29:0], 2'b00};
                end
            end
            OP_ADDI: begin
                wreg = iw[20:16];
                wval = addr;
            end
            OP_J:    nxt = {nxt[31:28], iw[25:0], 2'b00};
            default: wreg = 5'd0;
        endcase
        if (wreg != 5'd0) begin
            m_rf[wreg] = wval;
        end
        m_pc = nxt;
        return req;
    endfunction

    function automatic logic [31:0] random_instr(input int word);
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        int          kind;
        r    = $random(seed);
        kind = $unsigned($random(seed)) % 11;
        rs   = {2'b00, r[2:0]};
        rt   = {2'b00, r[5:3]};
        if (kind < 5) begin
            return r_type(fns[kind], {2'b00, r[8:6]}, rs, rt);
        end
        case (kind)
            5, 6:    return i_type(OP_ADDI, rs, rt, r[24:9]);
            7:       return i_type(OP_LW, rs, rt, r[24:9]);
            8:       return i_type(OP_SW, rs, rt, r[24:9]);
            9:       return i_type(OP_BEQ, rs, rt, {14'b0, r[10:9]});   // Forward only
            default: return j_type(26'(word + 1 + int'(r[10:9])));
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s %s: expected %h actual %h",
                                     test_name, what, exp, act));
        end
    endtask

    task automatic check_req(input string what, input dmem_req_t exp, input dmem_req_t act);
        // Address and data only matter for a store
        if (act.we !== exp.we || (exp.we && act !== exp)) begin
            report_failure($sformatf("mismatch %s %s: expected %h actual %h",
                                     test_name, what, exp, act));
        end
    endtask

    always @(posedge clk) begin
        if (running) begin
            check_word("pc", m_pc, pc);
            check_req("dmem_req", ref_step(imem[m_pc[11:2]]), dmem_req);
        end
    end

    task automatic run_test(input string name);
        int          cycles;
        logic [31:0] halt_pc;
        halt_pc = RESET_PC + 32'(4 * prog.size());
        for (int k = 0; k < 5; k++) begin
            prog.push_back(j_type(halt_pc[27:2]));  // Halt loop catches any overshoot
        end
        foreach (prog[k]) begin
            imem[BASE + k] = prog[k];
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]  = 32'(i) * 32'h9e37_79b9;
            m_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            m_rf[i] = 32'h0;
        end
        m_pc      = RESET_PC;
        test_name = name;
        rst       = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_req("store in reset", '0, dmem_req);
        end
        rst     = 1'b0;
        running = 1'b1;
        cycles  = 0;
        while (pc !== halt_pc) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2000) begin
                report_failure($sformatf("timeout: %s never reached its halt loop", name));
            end
        end
        running = 1'b0;
        for (int i = 1; i < 32; i++) begin
            check_word($sformatf("register %0d", i), m_rf[i], uut.u_datapath.rf.rf[i]);
        end
        for (int i = 0; i < 64; i++) begin
            check_word($sformatf("data word %0d", i), m_mem[i], dmem[i]);
        end
        rst = 1'b1;
        prog.delete();
    endtask

    initial begin
        for (int i = 0; i < 1024; i++) begin
            imem[i] = {6'h3f, 26'(i)};  // Unknown opcodes run as no-ops
        end
        // Negative operand with every result stored
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd1, 16'hfff9));
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd2, 16'd12));
        foreach (fns[k]) begin
            prog.push_back(r_type(fns[k], 5'd3, 5'd1, 5'd2));
            prog.push_back(i_type(OP_SW, 5'd0, 5'd3, 16'(4 * k)));
        end
        prog.push_back(r_type(FN_SLT, 5'd4, 5'd2, 5'd1));
        prog.push_back(i_type(OP_SW, 5'd0, 5'd4, 16'd20));
        run_test("rtype");
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd2, 16'd40));
        for (int k = 0; k < 4; k++) begin
            prog.push_back(i_type(OP_ADDI, 5'd0, 5'd1, 16'(33059 + 357 * k)));
            prog.push_back(i_type(OP_SW, 5'd2, 5'd1, 16'(12 * k)));
            prog.push_back(i_type(OP_LW, 5'd2, 5'd3, 16'(12 * k)));
            prog.push_back(i_type(OP_SW, 5'd2, 5'd3, 16'(12 * k + 4)));
        end
        prog.push_back(i_type(OP_LW, 5'd2, 5'd4, 16'hfff8));
        run_test("load_store");
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd1, 16'd5));
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd2, 16'd5));
        prog.push_back(i_type(OP_BEQ, 5'd1, 5'd2, 16'd1));     // Taken
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd3, 16'd1));
        prog.push_back(i_type(OP_BEQ, 5'd1, 5'd0, 16'd1));     // Not taken
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd4, 16'd2));
        prog.push_back(j_type(26'(BASE + prog.size() + 3)));
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd5, 16'd3));
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd6, 16'd4));
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd7, 16'd5));
        run_test("branch_jump");
        prog.push_back(i_type(OP_SW, 5'd0, 5'd0, 16'd16));     // Store sits at RESET_PC in reset
        prog.push_back(i_type(OP_ADDI, 5'd0, 5'd1, 16'd9));
        prog.push_back({6'b111111, 5'd0, 5'd1, 16'd4});
        prog.push_back({6'b101000, 5'd0, 5'd1, 16'd8});          // sb is not in the set
        prog.push_back({OP_RTYPE, 5'd1, 5'd1, 5'd1, 5'd0, 6'b000110});
        prog.push_back(i_type(OP_SW, 5'd0, 5'd1, 16'd12));
        run_test("unknown");
        for (int n = 0; n < 400; n++) begin
            prog.push_back(random_instr(BASE + n));
        end
        run_test("random");
        if (uut.u_controller.props.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            report_failure("the controller assertions failed during the run");
        end
    end

endmodule

//--- flist.f
src/mips_pkg.sv
src/maindec.sv
src/aludec.sv
src/controller.sv
src/alu.sv
src/regfile.sv
src/datapath.sv
src/mips.sv
testbench/mips_properties.sv
testbench/mips_tb.sv
